//--- design/MipsPkg.sv
package MipsPkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int dataW    = 32;
  localparam int regAddrW = 5;
  localparam int opW      = 6;
  localparam int aluOpW   = 4;
  localparam int fwdW     = 2;

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////
  localparam logic [opW-1:0] opR     = 6'h00;
  localparam logic [opW-1:0] opAddi  = 6'h08;
  localparam logic [opW-1:0] opAddiu = 6'h09;
  localparam logic [opW-1:0] opSlti  = 6'h0a;
  localparam logic [opW-1:0] opSltiu = 6'h0b;
  localparam logic [opW-1:0] opAndi  = 6'h0c;
  localparam logic [opW-1:0] opOri   = 6'h0d;
  localparam logic [opW-1:0] opXori  = 6'h0e;
  localparam logic [opW-1:0] opLui   = 6'h0f;

  // R-type funct field
  localparam logic [opW-1:0] fnSll  = 6'h00;
  localparam logic [opW-1:0] fnSrl  = 6'h02;
  localparam logic [opW-1:0] fnSra  = 6'h03;
  localparam logic [opW-1:0] fnAdd  = 6'h20;
  localparam logic [opW-1:0] fnAddu = 6'h21;
  localparam logic [opW-1:0] fnSub  = 6'h22;
  localparam logic [opW-1:0] fnSubu = 6'h23;
  localparam logic [opW-1:0] fnAnd  = 6'h24;
  localparam logic [opW-1:0] fnOr   = 6'h25;
  localparam logic [opW-1:0] fnXor  = 6'h26;
  localparam logic [opW-1:0] fnNor  = 6'h27;
  localparam logic [opW-1:0] fnSlt  = 6'h2a;
  localparam logic [opW-1:0] fnSltu = 6'h2b;

  ////////////////////////////////////////////////////////////
  // ALU operation codes
  ////////////////////////////////////////////////////////////
  localparam logic [aluOpW-1:0] aluAdd  = 4'd0;
  localparam logic [aluOpW-1:0] aluSub  = 4'd1;
  localparam logic [aluOpW-1:0] aluAnd  = 4'd2;
  localparam logic [aluOpW-1:0] aluOr   = 4'd3;
  localparam logic [aluOpW-1:0] aluXor  = 4'd4;
  localparam logic [aluOpW-1:0] aluNor  = 4'd5;
  localparam logic [aluOpW-1:0] aluSlt  = 4'd6;
  localparam logic [aluOpW-1:0] aluSltu = 4'd7;
  localparam logic [aluOpW-1:0] aluSll  = 4'd8;
  localparam logic [aluOpW-1:0] aluSrl  = 4'd9;
  localparam logic [aluOpW-1:0] aluSra  = 4'd10;
  localparam logic [aluOpW-1:0] aluLui  = 4'd11;

  // Forwarding selects
  localparam logic [fwdW-1:0] fwdNone = 2'd0;
  localparam logic [fwdW-1:0] fwdMem  = 2'd1;
  localparam logic [fwdW-1:0] fwdWb   = 2'd2;

  ////////////////////////////////////////////////////////////
  // Instruction word, R and I views
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [opW-1:0]      opcode;
    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic [regAddrW-1:0] rd;
    logic [regAddrW-1:0] shamt;
    logic [opW-1:0]      funct;
  } rFmtT;

  typedef struct packed {
    logic [opW-1:0]      opcode;
    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic [15:0]         imm;
  } iFmtT;

  typedef union packed {
    rFmtT r;
    iFmtT i;
  } instrT;

endpackage

//--- design/RegFile.sv
`timescale 1ns/10ps

module RegFile (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic [MipsPkg::regAddrW-1:0]  rdAddrA,
  input  logic [MipsPkg::regAddrW-1:0]  rdAddrB,
  output logic [MipsPkg::dataW-1:0]     rdDataA,
  output logic [MipsPkg::dataW-1:0]     rdDataB,
  input  logic                          wrEn,
  input  logic [MipsPkg::regAddrW-1:0]  wrAddr,
  input  logic [MipsPkg::dataW-1:0]     wrData
);
  import MipsPkg::*;

  // Register 0 has no storage
  logic [dataW-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int n = 1; n < 32; n++) begin
        regs[n] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Read ports with write-to-read bypass
  always_comb begin
    if (rdAddrA == '0)
      rdDataA = '0;
    else if (wrEn && (wrAddr == rdAddrA))
      rdDataA = wrData;
    else
      rdDataA = regs[rdAddrA];
  end

  always_comb begin
    if (rdAddrB == '0)
      rdDataB = '0;
    else if (wrEn && (wrAddr == rdAddrB))
      rdDataB = wrData;
    else
      rdDataB = regs[rdAddrB];
  end

endmodule

//--- design/ForwardUnit.sv
`timescale 1ns/10ps

module ForwardUnit (
  input  logic [MipsPkg::regAddrW-1:0] rs,
  input  logic [MipsPkg::regAddrW-1:0] rt,
  input  logic [MipsPkg::regAddrW-1:0] memDest,
  input  logic [MipsPkg::regAddrW-1:0] wbDest,
  input  logic                         memRegWrite,
  input  logic                         wbRegWrite,
  output logic [MipsPkg::fwdW-1:0]     fwdA,
  output logic [MipsPkg::fwdW-1:0]     fwdB
);
  import MipsPkg::*;

  // Younger result in MEM wins over WB
  always_comb begin
    if (memRegWrite && (memDest == rs))
      fwdA = fwdMem;
    else if (wbRegWrite && (wbDest == rs))
      fwdA = fwdWb;
    else
      fwdA = fwdNone;
  end

  // Same rule for the rt source
  always_comb begin
    if (memRegWrite && (memDest == rt))
      fwdB = fwdMem;
    else if (wbRegWrite && (wbDest == rt))
      fwdB = fwdWb;
    else
      fwdB = fwdNone;
  end

endmodule

//--- design/AluControl.sv
`timescale 1ns/10ps

module AluControl (
  input  logic [MipsPkg::opW-1:0]    opcode,
  input  logic [MipsPkg::opW-1:0]    funct,
  output logic [MipsPkg::aluOpW-1:0] aluOp
);
  import MipsPkg::*;

  logic [aluOpW-1:0] rTypeOp;

  ////////////////////////////////////////////////////////////
  // R-type, decoded from funct
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (funct)
      // No overflow trap, so signed and unsigned forms match
      fnAdd,
      fnAddu: rTypeOp = aluAdd;
      fnSub,
      fnSubu: rTypeOp = aluSub;
      fnAnd:  rTypeOp = aluAnd;
      fnOr:   rTypeOp = aluOr;
      fnXor:  rTypeOp = aluXor;
      fnNor:  rTypeOp = aluNor;
      fnSlt:  rTypeOp = aluSlt;
      fnSltu: rTypeOp = aluSltu;
      fnSll:  rTypeOp = aluSll;
      fnSrl:  rTypeOp = aluSrl;
      fnSra:  rTypeOp = aluSra;
      default: rTypeOp = aluAdd;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // I-type, decoded from opcode
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (opcode)
      opR:     aluOp = rTypeOp;
      opAddi,
      opAddiu: aluOp = aluAdd;
      opSlti:  aluOp = aluSlt;
      opSltiu: aluOp = aluSltu;
      opAndi:  aluOp = aluAnd;
      opOri:   aluOp = aluOr;
      opXori:  aluOp = aluXor;
      opLui:   aluOp = aluLui;
      // Unsupported opcodes never write back
      default: aluOp = aluAdd;
    endcase
  end

endmodule

//--- design/Alu.sv
`timescale 1ns/10ps

module Alu (
  input  logic [MipsPkg::aluOpW-1:0] aluOp,
  input  logic [MipsPkg::dataW-1:0]  a,
  input  logic [MipsPkg::dataW-1:0]  b,
  output logic [MipsPkg::dataW-1:0]  result
);
  import MipsPkg::*;

  // Shift amount from the low bits of A
  logic [4:0] shAmt;
  logic       lessSigned;
  logic       lessUnsigned;

  assign shAmt        = a[4:0];
  assign lessSigned   = $signed(a) < $signed(b);
  assign lessUnsigned = a < b;

  always_comb begin
    case (aluOp)
      // Wrapping arithmetic
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      // Bitwise logic
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluXor:  result = a ^ b;
      aluNor:  result = ~(a | b);
      // Compares give 1 or 0
      aluSlt:  result = {{(dataW-1){1'b0}}, lessSigned};
      aluSltu: result = {{(dataW-1){1'b0}}, lessUnsigned};
      // Shifts act on B
      aluSll:  result = b << shAmt;
      aluSrl:  result = b >> shAmt;
      aluSra:  result = $signed(b) >>> shAmt;
      // Immediate to upper half
      aluLui:  result = {b[15:0], 16'h0000};
      default: result = '0;
    endcase
  end

endmodule

//--- design/ExecuteStage.sv
`timescale 1ns/10ps

module ExecuteStage (
  input  logic [MipsPkg::dataW-1:0]    regDataA,
  input  logic [MipsPkg::dataW-1:0]    regDataB,
  input  logic [MipsPkg::dataW-1:0]    imm,
  input  logic [MipsPkg::regAddrW-1:0] rs,
  input  logic [MipsPkg::regAddrW-1:0] rt,
  input  logic [MipsPkg::regAddrW-1:0] rd,
  input  logic [MipsPkg::regAddrW-1:0] shamt,
  input  logic [MipsPkg::opW-1:0]      opcode,
  input  logic [MipsPkg::opW-1:0]      funct,
  input  logic                         srcAShamt,
  input  logic                         srcBImm,
  input  logic                         regDst,
  input  logic [MipsPkg::regAddrW-1:0] memDest,
  input  logic [MipsPkg::regAddrW-1:0] wbDest,
  input  logic                         memRegWrite,
  input  logic                         wbRegWrite,
  input  logic [MipsPkg::dataW-1:0]    memResult,
  input  logic [MipsPkg::dataW-1:0]    wbResult,
  output logic [MipsPkg::dataW-1:0]    aluResult,
  output logic [MipsPkg::regAddrW-1:0] destSel
);
  import MipsPkg::*;

  logic [fwdW-1:0]   fwdA;
  logic [fwdW-1:0]   fwdB;
  logic [aluOpW-1:0] aluOp;
  logic [dataW-1:0]  fwdDataA;
  logic [dataW-1:0]  fwdDataB;
  logic [dataW-1:0]  aluA;
  logic [dataW-1:0]  aluB;

  ////////////////////////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////////////////////////
  ForwardUnit ForwardUnit_i (
    .rs          (rs),
    .rt          (rt),
    .memDest     (memDest),
    .wbDest      (wbDest),
    .memRegWrite (memRegWrite),
    .wbRegWrite  (wbRegWrite),
    .fwdA        (fwdA),
    .fwdB        (fwdB)
  );

  // Replace register values before operand selection
  always_comb begin
    case (fwdA)
      fwdMem:  fwdDataA = memResult;
      fwdWb:   fwdDataA = wbResult;
      default: fwdDataA = regDataA;
    endcase
  end

  always_comb begin
    case (fwdB)
      fwdMem:  fwdDataB = memResult;
      fwdWb:   fwdDataB = wbResult;
      default: fwdDataB = regDataB;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Operands, ALU and destination
  ////////////////////////////////////////////////////////////
  // Shamt and immediate are never overridden
  assign aluA = srcAShamt ? {{(dataW-regAddrW){1'b0}}, shamt} : fwdDataA;
  assign aluB = srcBImm ? imm : fwdDataB;

  AluControl AluControl_i (
    .opcode (opcode),
    .funct  (funct),
    .aluOp  (aluOp)
  );

  Alu Alu_i (
    .aluOp  (aluOp),
    .a      (aluA),
    .b      (aluB),
    .result (aluResult)
  );

  // rd for R-type, rt for I-type
  assign destSel = regDst ? rd : rt;

endmodule

//--- design/ExecPipe.sv
`timescale 1ns/10ps

module ExecPipe (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         instrValid,
  input  MipsPkg::instrT               instr,
  output logic                         wbValid,
  output logic [MipsPkg::regAddrW-1:0] wbDest,
  output logic [MipsPkg::dataW-1:0]    wbData
);
  import MipsPkg::*;

  // Decode
  logic [dataW-1:0]    decRsData;
  logic [dataW-1:0]    decRtData;
  logic [dataW-1:0]    decImm;
  logic [regAddrW-1:0] decDest;
  logic                decSrcAShamt;
  logic                decSrcBImm;
  logic                decRegDst;
  logic                decLegal;
  logic                decRegWrite;
  // ID/EX
  logic [dataW-1:0]    exRsData;
  logic [dataW-1:0]    exRtData;
  logic [dataW-1:0]    exImm;
  logic [regAddrW-1:0] exRs;
  logic [regAddrW-1:0] exRt;
  logic [regAddrW-1:0] exRd;
  logic [regAddrW-1:0] exShamt;
  logic [opW-1:0]      exOpcode;
  logic [opW-1:0]      exFunct;
  logic                exSrcAShamt;
  logic                exSrcBImm;
  logic                exRegDst;
  logic                exRegWrite;
  logic [dataW-1:0]    exResult;
  logic [regAddrW-1:0] exDest;
  // EX/MEM and MEM/WB
  logic [dataW-1:0]    memResult;
  logic [regAddrW-1:0] memDest;
  logic                memRegWrite;
  logic                wbRegWrite;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////
  RegFile RegFile_i (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddrA (instr.r.rs),
    .rdAddrB (instr.r.rt),
    .rdDataA (decRsData),
    .rdDataB (decRtData),
    .wrEn    (wbRegWrite),
    .wrAddr  (wbDest),
    .wrData  (wbData)
  );

  always_comb begin
    // Sign extension unless a logic immediate
    decImm       = {{16{instr.i.imm[15]}}, instr.i.imm};
    decSrcAShamt = 1'b0;
    decSrcBImm   = 1'b1;
    decRegDst    = 1'b0;
    decLegal     = 1'b1;
    case (instr.r.opcode)
      opR: begin
        decSrcBImm = 1'b0;
        decRegDst  = 1'b1;
        case (instr.r.funct)
          // Constant shifts only
          fnSll, fnSrl, fnSra: decSrcAShamt = 1'b1;
          fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr,
          fnXor, fnNor, fnSlt, fnSltu: decSrcAShamt = 1'b0;
          default: decLegal = 1'b0;
        endcase
      end
      opAddi, opAddiu, opSlti, opSltiu: decSrcBImm = 1'b1;
      opAndi, opOri, opXori, opLui: decImm = {16'h0000, instr.i.imm};
      default: decLegal = 1'b0;
    endcase
  end

  // No write for bubbles, bad codes or register 0
  assign decDest     = decRegDst ? instr.r.rd : instr.r.rt;
  assign decRegWrite = instrValid && decLegal && (decDest != '0);

  ////////////////////////////////////////////////////////////
  // Pipeline latches
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      exRegWrite  <= 1'b0;
      memRegWrite <= 1'b0;
      wbRegWrite  <= 1'b0;
    end else begin
      exRegWrite  <= decRegWrite;
      memRegWrite <= exRegWrite;
      wbRegWrite  <= memRegWrite;
    end
  end

  // Payload, qualified by the regWrite bits
  always_ff @(posedge clk) begin
    exRsData    <= decRsData;
    exRtData    <= decRtData;
    exImm       <= decImm;
    exRs        <= instr.r.rs;
    exRt        <= instr.r.rt;
    exRd        <= instr.r.rd;
    exShamt     <= instr.r.shamt;
    exOpcode    <= instr.r.opcode;
    exFunct     <= instr.r.funct;
    exSrcAShamt <= decSrcAShamt;
    exSrcBImm   <= decSrcBImm;
    exRegDst    <= decRegDst;
    memResult   <= exResult;
    memDest     <= exDest;
    wbData      <= memResult;
    wbDest      <= memDest;
  end

  ////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////
  ExecuteStage ExecuteStage_i (
    .regDataA    (exRsData),
    .regDataB    (exRtData),
    .imm         (exImm),
    .rs          (exRs),
    .rt          (exRt),
    .rd          (exRd),
    .shamt       (exShamt),
    .opcode      (exOpcode),
    .funct       (exFunct),
    .srcAShamt   (exSrcAShamt),
    .srcBImm     (exSrcBImm),
    .regDst      (exRegDst),
    .memDest     (memDest),
    .wbDest      (wbDest),
    .memRegWrite (memRegWrite),
    .wbRegWrite  (wbRegWrite),
    .memResult   (memResult),
    .wbResult    (wbData),
    .aluResult   (exResult),
    .destSel     (exDest)
  );

  // Register-0 writes were dropped in decode
  assign wbValid = wbRegWrite;

endmodule

//--- test/ExecPipe_sva.sv
`timescale 1ns/10ps

module ExecPipeSva (
  input logic                         clk,
  input logic                         rstN,
  input logic                         wbValid,
  input logic [MipsPkg::regAddrW-1:0] wbDest,
  input logic [MipsPkg::dataW-1:0]    wbData,
  input logic [MipsPkg::regAddrW-1:0] exRs,
  input logic [MipsPkg::regAddrW-1:0] exRt,
  input logic [MipsPkg::regAddrW-1:0] memDest,
  input logic                         memRegWrite,
  input logic                         wbRegWrite,
  input logic [MipsPkg::fwdW-1:0]     fwdA,
  input logic [MipsPkg::fwdW-1:0]     fwdB
);
  import MipsPkg::*;

  // Write-back quiet right after reset
  resetQuiet: assert property (@(posedge clk) !rstN |=> !wbValid)
    else $error("wbValid high in the cycle after reset");

  // Valid write-back has a real destination and known data
  wbClean: assert property (@(posedge clk) disable iff (!rstN)
    wbValid |-> (wbDest != '0) && !$isunknown(wbData))
    else $error("write-back to register 0 or with unknown data");

  // Double match on a source, MEM holds the younger value
  memFirstA: assert property (@(posedge clk) disable iff (!rstN)
    (memRegWrite && wbRegWrite && (memDest == exRs) && (wbDest == exRs)) |-> (fwdA == fwdMem))
    else $error("rs forwarding took WB over MEM");

  memFirstB: assert property (@(posedge clk) disable iff (!rstN)
    (memRegWrite && wbRegWrite && (memDest == exRt) && (wbDest == exRt)) |-> (fwdB == fwdMem))
    else $error("rt forwarding took WB over MEM");

endmodule

//--- test/tbExecPipe.sv
`timescale 1ns/10ps

module tbExecPipe;
  import MipsPkg::*;

  localparam int halfPeriod   = 10;
  localparam int driveDelay   = 2;
  localparam int numInstr     = 600;
  localparam int resetCycles  = 3;
  localparam int idleCycles   = 4;
  localparam int pipeCycles   = 3;
  // Bubbles, pipeline drain and a margin on top of the stream
  localparam int maxCycles = resetCycles + idleCycles + numInstr + numInstr / 8
                             + pipeCycles + 50;

  logic                clk = 1'b0;
  logic                rstN;
  logic                instrValid;
  instrT               instr;
  logic                wbValid;
  logic [regAddrW-1:0] wbDest;
  logic [dataW-1:0]    wbData;

  // Reference model state
  logic [31:0]         lcgState = 32'h1546b5fa;
  logic [dataW-1:0]    archRegs [32];
  logic [regAddrW-1:0] expDest [$];
  logic [dataW-1:0]    expData [$];
  int                  destErrors = 0;
  int                  dataErrors = 0;
  int                  flowErrors = 0;
  int                  cycleCount = 0;

  always #halfPeriod clk = ~clk;

  ExecPipe ExecPipe_i (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .wbValid    (wbValid),
    .wbDest     (wbDest),
    .wbData     (wbData)
  );

  bind ExecPipe ExecPipeSva ExecPipeSva_i (
    .clk         (clk),
    .rstN        (rstN),
    .wbValid     (wbValid),
    .wbDest      (wbDest),
    .wbData      (wbData),
    .exRs        (exRs),
    .exRt        (exRt),
    .memDest     (memDest),
    .memRegWrite (memRegWrite),
    .wbRegWrite  (wbRegWrite),
    .fwdA        (ExecuteStage_i.fwdA),
    .fwdB        (ExecuteStage_i.fwdB)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus generation
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // One of the 21 supported ops, registers 0 to 7 only
  task automatic makeInstr(output instrT ins);
    logic [31:0] pick;
    logic [31:0] fields;
    int          sel;
    pick   = nextRand();
    fields = nextRand();
    sel    = int'(pick[31:16] % 16'd21);
    ins    = '0;
    ins.r.rs = {2'b00, fields[31:29]};
    ins.r.rt = {2'b00, fields[28:26]};
    if (sel < 13) begin
      ins.r.opcode = opR;
      ins.r.rd     = {2'b00, fields[25:23]};
      case (sel)
        0:       ins.r.funct = fnAdd;
        1:       ins.r.funct = fnAddu;
        2:       ins.r.funct = fnSub;
        3:       ins.r.funct = fnSubu;
        4:       ins.r.funct = fnAnd;
        5:       ins.r.funct = fnOr;
        6:       ins.r.funct = fnXor;
        7:       ins.r.funct = fnNor;
        8:       ins.r.funct = fnSlt;
        9:       ins.r.funct = fnSltu;
        10:      ins.r.funct = fnSll;
        11:      ins.r.funct = fnSrl;
        default: ins.r.funct = fnSra;
      endcase
      // Shift amount only for the constant shifts
      if (sel >= 10)
        ins.r.shamt = fields[22:18];
    end else begin
      case (sel)
        13:      ins.i.opcode = opAddi;
        14:      ins.i.opcode = opAddiu;
        15:      ins.i.opcode = opSlti;
        16:      ins.i.opcode = opSltiu;
        17:      ins.i.opcode = opAndi;
        18:      ins.i.opcode = opOri;
        19:      ins.i.opcode = opXori;
        default: ins.i.opcode = opLui;
      endcase
      ins.i.imm = fields[15:0];
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Architectural model, one instruction at a time
  ////////////////////////////////////////////////////////////
  task automatic executeModel(input instrT ins);
    logic [dataW-1:0]    a;
    logic [dataW-1:0]    b;
    logic [dataW-1:0]    sImm;
    logic [dataW-1:0]    zImm;
    logic [dataW-1:0]    res;
    logic [regAddrW-1:0] dest;
    a    = archRegs[ins.r.rs];
    b    = archRegs[ins.r.rt];
    sImm = {{16{ins.i.imm[15]}}, ins.i.imm};
    zImm = {16'h0000, ins.i.imm};
    res  = '0;
    if (ins.r.opcode == opR) begin
      dest = ins.r.rd;
      case (ins.r.funct)
        fnAdd, fnAddu: res = a + b;
        fnSub, fnSubu: res = a - b;
        fnAnd:   res = a & b;
        fnOr:    res = a | b;
        fnXor:   res = a ^ b;
        fnNor:   res = ~(a | b);
        fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        fnSltu:  res = (a < b) ? 32'd1 : 32'd0;
        fnSll:   res = b << ins.r.shamt;
        fnSrl:   res = b >> ins.r.shamt;
        default: res = $signed(b) >>> ins.r.shamt;
      endcase
    end else begin
      dest = ins.i.rt;
      case (ins.i.opcode)
        opAddi, opAddiu: res = a + sImm;
        opSlti:  res = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
        // Unsigned compare, still against the sign-extended value
        opSltiu: res = (a < sImm) ? 32'd1 : 32'd0;
        opAndi:  res = a & zImm;
        opOri:   res = a | zImm;
        opXori:  res = a ^ zImm;
        default: res = {ins.i.imm, 16'h0000};
      endcase
    end
    // Register 0 stays zero and never shows on write-back
    if (dest != '0) begin
      archRegs[dest] = res;
      expDest.push_back(dest);
      expData.push_back(res);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks and write-back monitor
  ////////////////////////////////////////////////////////////
  task automatic checkDest(input logic [regAddrW-1:0] actual,
                           input logic [regAddrW-1:0] expected);
    if (actual !== expected) begin
      destErrors++;
      $display("CHECK FAILED wbDest at %0t: got 0x%h, expected 0x%h", $time, actual, expected);
    end
  endtask

  task automatic checkData(input logic [dataW-1:0] actual,
                           input logic [dataW-1:0] expected);
    if (actual !== expected) begin
      dataErrors++;
      $display("CHECK FAILED wbData at %0t: got 0x%h, expected 0x%h", $time, actual, expected);
    end
  endtask

  // Sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin
    if (rstN && (wbValid === 1'b1)) begin
      if (expDest.size() == 0) begin
        flowErrors++;
        $display("Write-back to register %0d at %0t with nothing outstanding", wbDest, $time);
      end else begin
        checkDest(wbDest, expDest.pop_front());
        checkData(wbData, expData.pop_front());
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= maxCycles) begin
      $display("Timeout after %0d cycles, %0d write-backs missing", cycleCount, expDest.size());
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    instrT       ins;
    logic [31:0] gap;
    int          sent;
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    sent       = 0;
    for (int n = 0; n < 32; n++) begin
      archRegs[n] = '0;
    end
    repeat (resetCycles) @(posedge clk);
    #driveDelay rstN = 1'b1;
    // Idle stretch, nothing may come out
    repeat (idleCycles) @(posedge clk);
    while (sent < numInstr) begin
      @(posedge clk);
      #driveDelay;
      gap = nextRand();
      makeInstr(ins);
      instr = ins;
      // Roughly one bubble in eight, with a live-looking word on the bus
      if (gap[31:29] == 3'b000) begin
        instrValid = 1'b0;
      end else begin
        instrValid = 1'b1;
        executeModel(ins);
        sent++;
      end
    end
    @(posedge clk);
    #driveDelay instrValid = 1'b0;
    // Pipeline depth, then a few more cycles to catch stray write-backs
    repeat (pipeCycles + 2) @(posedge clk);
    if (expDest.size() != 0) begin
      flowErrors++;
      $display("%0d expected write-backs never appeared", expDest.size());
    end
    $display("Errors: dest %0d, data %0d, flow %0d", destErrors, dataErrors, flowErrors);
    if ((destErrors + dataErrors + flowErrors) == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
design/MipsPkg.sv
design/RegFile.sv
design/ForwardUnit.sv
design/AluControl.sv
design/Alu.sv
design/ExecuteStage.sv
design/ExecPipe.sv
test/ExecPipe_sva.sv
test/tbExecPipe.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tbExecPipe
RTL_TOP   := ExecPipe
FILELIST  := vlog.f
BUILD     := obj_dir
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
